// ==== src/neoPixelPkg.sv ====
`default_nettype none

package neoPixelPkg;

  localparam int ADDR_BITS = 18;
  localparam int DATA_BITS = 8;
  localparam int MAX_BITS  = 13; // frame length register, counts bytes from 0
  localparam int SIZE_BITS = 14;

  // the two top address bits select what a bus access talks to
  typedef enum logic [1:0] {
    VIRT_REGION  = 2'd0,
    DELTA_REGION = 2'd1,
    RAW_REGION   = 2'd2,
    REG_REGION   = 2'd3
  } regionE;

  localparam logic [3:0] REG_MAX_LO    = 4'd0;
  localparam logic [3:0] REG_MAX_HI    = 4'd1;
  localparam logic [3:0] REG_CTRL      = 4'd2;
  localparam logic [3:0] REG_STATE     = 4'd3;
  localparam logic [3:0] REG_WIDTH_LO  = 4'd5;
  localparam logic [3:0] REG_WIDTH_HI  = 4'd6;
  localparam logic [3:0] REG_HEIGHT_LO = 4'd7;
  localparam logic [3:0] REG_HEIGHT_HI = 4'd8;

  // bit positions inside the control register
  localparam int CTRL_INIT  = 0;
  localparam int CTRL_LIMIT = 1;
  localparam int CTRL_RUN   = 2;
  localparam int CTRL_LOOP  = 3;
  localparam int CTRL_32BIT = 4;

  // one delta table word, read as a plain byte index in 8-bit mode or as a
  // pixel index with a channel field in 32-bit mode
  typedef union packed {
    logic [15:0] flat;
    struct packed {
      logic [13:0] pixel;
      logic [1:0]  channel; // overwritten by the low address bits of the access
    } chan32;
  } deltaEntryU;

endpackage

`default_nettype wire

// ==== src/pixelRam.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixelRam #(
  parameter  int DEPTH_END = 63,
  parameter  int WIDTH     = 8,
  localparam int IX_BITS   = $clog2(DEPTH_END + 1)
)(
  input  logic               busClk,
  input  logic               wr,
  input  logic [IX_BITS-1:0] wAddr,
  input  logic [WIDTH-1:0]   dIn,
  input  logic [IX_BITS-1:0] rAddr,
  output logic [WIDTH-1:0]   dOut
);

  logic [WIDTH-1:0] mem [0:DEPTH_END];

  // read is registered so the RAM maps onto a pipelined block RAM
  always_ff @(posedge busClk) begin
    if (wr) begin
      mem[wAddr] <= dIn;
    end
    dOut <= mem[rAddr];
  end

  // writers must stay inside the buffer they were sized for
  assert property (@(posedge busClk) wr |-> (wAddr <= IX_BITS'(DEPTH_END)));

endmodule

`default_nettype wire

// ==== src/neoPixelRegisters.sv ====
`timescale 1ns/1ns
`default_nettype none

module neoPixelRegisters #(
  parameter  int BUFFER_END   = 63,
  parameter  int VIRTUAL_END  = 63,
  localparam int BUFFER_BITS  = $clog2(BUFFER_END + 1),
  localparam int VIRTUAL_BITS = $clog2(VIRTUAL_END + 1)
)(
  input  logic                              busClk,
  input  logic                              rstN,
  input  logic [neoPixelPkg::ADDR_BITS-1:0] busAddr,
  input  logic [neoPixelPkg::DATA_BITS-1:0] busDataIn,
  input  logic                              busWrite,
  input  logic                              busRead,
  output logic [neoPixelPkg::DATA_BITS-1:0] busDataOut,
  output logic                              busReady,
  input  logic [BUFFER_BITS-1:0]            pixelIx,
  output logic [neoPixelPkg::DATA_BITS-1:0] pixelByte,
  input  logic                              streamSyncOf,
  input  logic                              syncStart,
  input  logic                              state,
  input  logic                              initSlowDone,
  output logic [neoPixelPkg::MAX_BITS-1:0]  regMax,
  output logic                              regCtrlLimit,
  output logic                              regCtrlRun,
  output logic                              initSlow
);

  logic                               regCtrlInit;
  logic                               regCtrlLoop;
  logic                               regCtrl32bit;
  logic [neoPixelPkg::SIZE_BITS-1:0]  regWidth;  // stored for software only
  logic [neoPixelPkg::SIZE_BITS-1:0]  regHeight;
  neoPixelPkg::regionE                region;
  logic                               virtStart;
  logic [2:0]                         virtState;
  logic [VIRTUAL_BITS-1:0]            virtIx;
  logic [1:0]                         virtChan;
  logic [neoPixelPkg::DATA_BITS-1:0]  virtData;
  logic                               rawWr;
  logic [BUFFER_BITS-1:0]             rawWAddr;
  logic [neoPixelPkg::DATA_BITS-1:0]  rawWData;
  logic                               deltaWr;
  logic [VIRTUAL_BITS-1:0]            deltaWAddr;
  logic [15:0]                        deltaWData;
  logic [7:0]                         deltaLo;
  logic [15:0]                        deltaDOut;
  neoPixelPkg::deltaEntryU            mappedEntry;
  logic [neoPixelPkg::DATA_BITS-1:0]  ctrlByte;

  assign region    = neoPixelPkg::regionE'(busAddr[neoPixelPkg::ADDR_BITS-1 -: 2]);
  assign virtStart = busWrite && (region == neoPixelPkg::VIRT_REGION) && (virtState == 3'd0);

  // frame buffer, second port belongs to the streamer
  pixelRam #(
    .DEPTH_END(BUFFER_END),
    .WIDTH(8)
  ) rawRam (
    .busClk(busClk),
    .wr(rawWr),
    .wAddr(rawWAddr),
    .dIn(rawWData),
    .rAddr(pixelIx),
    .dOut(pixelByte)
  );

  pixelRam #(
    .DEPTH_END(VIRTUAL_END),
    .WIDTH(16)
  ) deltaRam (
    .busClk(busClk),
    .wr(deltaWr),
    .wAddr(deltaWAddr),
    .dIn(deltaWData),
    .rAddr(virtIx),
    .dOut(deltaDOut)
  );

  // in 32-bit mode the stored channel is replaced by the one the master addressed
  always_comb begin
    mappedEntry.flat = deltaDOut;
    if (regCtrl32bit) begin
      mappedEntry.chan32.channel = virtChan;
    end
  end

  always_comb begin
    ctrlByte = '0;
    ctrlByte[neoPixelPkg::CTRL_INIT]  = regCtrlInit;
    ctrlByte[neoPixelPkg::CTRL_LIMIT] = regCtrlLimit;
    ctrlByte[neoPixelPkg::CTRL_RUN]   = regCtrlRun;
    ctrlByte[neoPixelPkg::CTRL_LOOP]  = regCtrlLoop;
    ctrlByte[neoPixelPkg::CTRL_32BIT] = regCtrl32bit;
  end

  always_ff @(posedge busClk or negedge rstN) begin
    if (!rstN) begin
      busReady     <= 1'b1;
      virtState    <= 3'd0;
      rawWr        <= 1'b0;
      deltaWr      <= 1'b0;
      regMax       <= '0;
      regWidth     <= '0;
      regHeight    <= '0;
      regCtrlInit  <= 1'b0;
      regCtrlLimit <= 1'b0;
      regCtrlRun   <= 1'b0;
      regCtrlLoop  <= 1'b0;
      regCtrl32bit <= 1'b0;
      initSlow     <= 1'b0;
    end else begin
      rawWr   <= busWrite && (region == neoPixelPkg::RAW_REGION);
      deltaWr <= busWrite && (region == neoPixelPkg::DELTA_REGION) && busAddr[0]; // high byte

      // stages 1-3 wait on the delta read, 4 writes, 5 lets it land, 6 frees the bus
      if (virtStart) begin
        busReady  <= 1'b0;
        virtState <= 3'd1;
      end else if (virtState != 3'd0) begin
        virtState <= (virtState == 3'd6) ? 3'd0 : virtState + 3'd1;
        if (virtState == 3'd4) begin
          rawWr <= 1'b1;
        end
        if (virtState == 3'd6) begin
          busReady <= 1'b1;
        end
      end

      if (streamSyncOf) begin
        regCtrlRun <= regCtrlLoop;
      end
      if (syncStart) begin
        regCtrlRun <= 1'b1;
      end
      if (regCtrlInit) begin
        regCtrlLimit <= 1'b0;
        regCtrlRun   <= 1'b0;
        regCtrlLoop  <= 1'b0;
        regCtrl32bit <= 1'b0;
        initSlow     <= 1'b1;
      end
      if (initSlowDone) begin
        regCtrlInit <= 1'b0;
        initSlow    <= 1'b0;
      end

      if (busWrite && (region == neoPixelPkg::REG_REGION)) begin
        case (busAddr[3:0])
          neoPixelPkg::REG_MAX_LO: regMax[7:0] <= busDataIn;
          neoPixelPkg::REG_MAX_HI:
            regMax[neoPixelPkg::MAX_BITS-1:8] <= busDataIn[neoPixelPkg::MAX_BITS-9:0];
          neoPixelPkg::REG_CTRL: begin
            regCtrlInit  <= busDataIn[neoPixelPkg::CTRL_INIT];
            regCtrlLimit <= busDataIn[neoPixelPkg::CTRL_LIMIT];
            regCtrlRun   <= busDataIn[neoPixelPkg::CTRL_RUN];
            regCtrlLoop  <= busDataIn[neoPixelPkg::CTRL_LOOP];
            regCtrl32bit <= busDataIn[neoPixelPkg::CTRL_32BIT];
          end
          neoPixelPkg::REG_WIDTH_LO: regWidth[7:0] <= busDataIn;
          neoPixelPkg::REG_WIDTH_HI:
            regWidth[neoPixelPkg::SIZE_BITS-1:8] <= busDataIn[neoPixelPkg::SIZE_BITS-9:0];
          neoPixelPkg::REG_HEIGHT_LO: regHeight[7:0] <= busDataIn;
          neoPixelPkg::REG_HEIGHT_HI:
            regHeight[neoPixelPkg::SIZE_BITS-1:8] <= busDataIn[neoPixelPkg::SIZE_BITS-9:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge busClk) begin
    if (virtStart) begin
      virtIx   <= regCtrl32bit ? busAddr[VIRTUAL_BITS+1:2] : busAddr[VIRTUAL_BITS-1:0];
      virtChan <= busAddr[1:0];
      virtData <= busDataIn;
    end

    if (busWrite && (region == neoPixelPkg::RAW_REGION)) begin
      rawWAddr <= busAddr[BUFFER_BITS-1:0];
      rawWData <= busDataIn;
    end else if (virtState == 3'd4) begin
      rawWAddr <= mappedEntry.flat[BUFFER_BITS-1:0];
      rawWData <= virtData;
    end

    // a delta entry is committed when its high byte arrives
    if (busWrite && (region == neoPixelPkg::DELTA_REGION)) begin
      if (!busAddr[0]) begin
        deltaLo <= busDataIn;
      end else begin
        deltaWAddr <= busAddr[VIRTUAL_BITS:1];
        deltaWData <= {busDataIn, deltaLo};
      end
    end

    if (busRead) begin
      if (region != neoPixelPkg::REG_REGION) begin
        busDataOut <= 8'hFF; // buffers have no read path
      end else begin
        case (busAddr[3:0])
          neoPixelPkg::REG_MAX_LO:    busDataOut <= regMax[7:0];
          neoPixelPkg::REG_MAX_HI:    busDataOut <= 8'(regMax[neoPixelPkg::MAX_BITS-1:8]);
          neoPixelPkg::REG_CTRL:      busDataOut <= ctrlByte;
          neoPixelPkg::REG_STATE:     busDataOut <= {7'd0, state};
          neoPixelPkg::REG_WIDTH_LO:  busDataOut <= regWidth[7:0];
          neoPixelPkg::REG_WIDTH_HI:  busDataOut <= 8'(regWidth[neoPixelPkg::SIZE_BITS-1:8]);
          neoPixelPkg::REG_HEIGHT_LO: busDataOut <= regHeight[7:0];
          neoPixelPkg::REG_HEIGHT_HI: busDataOut <= 8'(regHeight[neoPixelPkg::SIZE_BITS-1:8]);
          default:                    busDataOut <= 8'h00;
        endcase
      end
    end
  end

  // the master only sees busReady, so it must track the sequencer exactly
  assert property (@(posedge busClk) disable iff (!rstN) busReady == (virtState == 3'd0));

  // the streamer may only finish an init that this block asked for
  assert property (@(posedge busClk) disable iff (!rstN) initSlowDone |-> initSlow);

endmodule

`default_nettype wire

// ==== src/pixelStreamer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixelStreamer #(
  parameter  int BUFFER_END   = 63,
  parameter  int BIT_CYCLES   = 25,
  parameter  int T0H_CYCLES   = 8,
  parameter  int T1H_CYCLES   = 16,
  parameter  int RESET_CYCLES = 1000,
  localparam int BUFFER_BITS  = $clog2(BUFFER_END + 1)
)(
  input  logic                              busClk,
  input  logic                              rstN,
  input  logic [neoPixelPkg::MAX_BITS-1:0]  regMax,
  input  logic                              regCtrlLimit,
  input  logic                              regCtrlRun,
  input  logic                              initSlow,
  output logic [BUFFER_BITS-1:0]            pixelIx,
  input  logic [neoPixelPkg::DATA_BITS-1:0] pixelByte,
  output logic                              streamSyncOf,
  output logic                              state,
  output logic                              initSlowDone,
  output logic                              pixelOut
);

  localparam int MAX_W    = neoPixelPkg::MAX_BITS;
  localparam int CNT_BITS = $clog2(BIT_CYCLES + 1);
  localparam int GAP_BITS = $clog2(RESET_CYCLES + 1);

  localparam logic [1:0] IDLE  = 2'd0;
  localparam logic [1:0] FETCH = 2'd1;
  localparam logic [1:0] SHIFT = 2'd2;
  localparam logic [1:0] LATCH = 2'd3;

  logic [1:0]                        fsm;
  logic [CNT_BITS-1:0]               bitCnt;
  logic [2:0]                        bitIx;
  logic [GAP_BITS-1:0]               gapCnt;
  logic [neoPixelPkg::DATA_BITS-1:0] shiftReg;
  logic                              lastByte; // byte in shiftReg closes the frame
  logic                              initMode;
  logic [MAX_W-1:0]                  frameEnd;
  logic                              bitEnd;
  logic                              byteEnd;
  logic                              loadByte;
  logic                              lineHigh;

  assign frameEnd = regCtrlLimit ? regMax : BUFFER_END[MAX_W-1:0];
  assign bitEnd   = (bitCnt == CNT_BITS'(BIT_CYCLES - 1));
  assign byteEnd  = (fsm == SHIFT) && bitEnd && (bitIx == 3'd0);
  assign loadByte = (fsm == FETCH) || (byteEnd && !lastByte && !initSlow);
  assign lineHigh = (fsm == SHIFT) &&
                    (bitCnt < (shiftReg[7] ? CNT_BITS'(T1H_CYCLES) : CNT_BITS'(T0H_CYCLES)));
  assign state    = (fsm != IDLE);

  always_ff @(posedge busClk or negedge rstN) begin
    if (!rstN) begin
      fsm          <= IDLE;
      bitCnt       <= '0;
      bitIx        <= 3'd7;
      gapCnt       <= '0;
      pixelIx      <= '0;
      lastByte     <= 1'b0;
      initMode     <= 1'b0;
      streamSyncOf <= 1'b0;
      initSlowDone <= 1'b0;
      pixelOut     <= 1'b0;
    end else begin
      streamSyncOf <= 1'b0;
      initSlowDone <= 1'b0;
      pixelOut     <= lineHigh;
      case (fsm)
        IDLE: begin
          // the pulse guards stop a request that is being cleared from restarting
          if (initSlow && !initSlowDone) begin
            initMode <= 1'b1;
            gapCnt   <= '0;
            fsm      <= LATCH;
          end else if (regCtrlRun && !streamSyncOf) begin
            fsm <= FETCH;
          end
        end
        FETCH: begin
          bitCnt <= '0;
          bitIx  <= 3'd7;
          fsm    <= SHIFT;
        end
        SHIFT: begin
          bitCnt <= bitEnd ? '0 : bitCnt + 1'b1;
          if (bitEnd) begin
            bitIx <= bitIx - 3'd1;
            if (initSlow || (bitIx == 3'd0 && lastByte)) begin
              initMode <= initSlow; // init cuts the frame at a bit boundary
              gapCnt   <= '0;
              pixelIx  <= '0;
              fsm      <= LATCH;
            end
          end
        end
        LATCH: begin
          gapCnt <= gapCnt + 1'b1;
          if (gapCnt == GAP_BITS'(RESET_CYCLES - 1)) begin
            streamSyncOf <= !initMode;
            initSlowDone <= initMode;
            initMode     <= 1'b0;
            fsm          <= IDLE;
          end
        end
        default: fsm <= IDLE;
      endcase

      // the next byte is already on its way while this one shifts out
      if (loadByte) begin
        lastByte <= (MAX_W'(pixelIx) == frameEnd);
        pixelIx  <= pixelIx + 1'b1;
      end
    end
  end

  always_ff @(posedge busClk) begin
    if (loadByte) begin
      shiftReg <= pixelByte;
    end else if ((fsm == SHIFT) && bitEnd) begin
      shiftReg <= {shiftReg[6:0], 1'b0}; // MSB goes out first
    end
  end

  assert property (@(posedge busClk) disable iff (!rstN) streamSyncOf |=> !streamSyncOf);
  assert property (@(posedge busClk) disable iff (!rstN) initSlowDone |=> !initSlowDone);
  assert property (@(posedge busClk) disable iff (!rstN) bitCnt < CNT_BITS'(BIT_CYCLES));

endmodule

`default_nettype wire

// ==== src/neoPixelTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module neoPixelTop #(
  parameter int BUFFER_END   = 255,
  parameter int VIRTUAL_END  = 255,
  parameter int BIT_CYCLES   = 25,
  parameter int T0H_CYCLES   = 8,
  parameter int T1H_CYCLES   = 16,
  parameter int RESET_CYCLES = 1000
)(
  input  logic                              busClk,
  input  logic                              rstN,
  input  logic [neoPixelPkg::ADDR_BITS-1:0] busAddr,
  input  logic [neoPixelPkg::DATA_BITS-1:0] busDataIn,
  input  logic                              busWrite,
  input  logic                              busRead,
  output logic [neoPixelPkg::DATA_BITS-1:0] busDataOut,
  output logic                              busReady,
  input  logic                              syncStart,
  output logic                              pixelOut
);

  localparam int BUFFER_BITS = $clog2(BUFFER_END + 1);

  logic [BUFFER_BITS-1:0]            pixelIx;
  logic [neoPixelPkg::DATA_BITS-1:0] pixelByte;
  logic [neoPixelPkg::MAX_BITS-1:0]  regMax;
  logic                              regCtrlLimit;
  logic                              regCtrlRun;
  logic                              initSlow;
  logic                              initSlowDone;
  logic                              streamSyncOf;
  logic                              state;

  neoPixelRegisters #(
    .BUFFER_END(BUFFER_END),
    .VIRTUAL_END(VIRTUAL_END)
  ) registers (
    .busClk(busClk),
    .rstN(rstN),
    .busAddr(busAddr),
    .busDataIn(busDataIn),
    .busWrite(busWrite),
    .busRead(busRead),
    .busDataOut(busDataOut),
    .busReady(busReady),
    .pixelIx(pixelIx),
    .pixelByte(pixelByte),
    .streamSyncOf(streamSyncOf),
    .syncStart(syncStart),
    .state(state),
    .initSlowDone(initSlowDone),
    .regMax(regMax),
    .regCtrlLimit(regCtrlLimit),
    .regCtrlRun(regCtrlRun),
    .initSlow(initSlow)
  );

  pixelStreamer #(
    .BUFFER_END(BUFFER_END),
    .BIT_CYCLES(BIT_CYCLES),
    .T0H_CYCLES(T0H_CYCLES),
    .T1H_CYCLES(T1H_CYCLES),
    .RESET_CYCLES(RESET_CYCLES)
  ) streamer (
    .busClk(busClk),
    .rstN(rstN),
    .regMax(regMax),
    .regCtrlLimit(regCtrlLimit),
    .regCtrlRun(regCtrlRun),
    .initSlow(initSlow),
    .pixelIx(pixelIx),
    .pixelByte(pixelByte),
    .streamSyncOf(streamSyncOf),
    .state(state),
    .initSlowDone(initSlowDone),
    .pixelOut(pixelOut)
  );

endmodule

`default_nettype wire

// ==== sim/neoPixelTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module neoPixelTb;

  localparam int BUFFER_END   = 63;
  localparam int VIRTUAL_END  = 63;
  localparam int BIT_CYCLES   = 8;
  localparam int T0H_CYCLES   = 2;
  localparam int T1H_CYCLES   = 5;
  localparam int RESET_CYCLES = 40;
  // five eight-byte frames, one init gap and a margin for each of the six tests
  localparam int FRAME_CYCLES   = 8 * 8 * BIT_CYCLES + RESET_CYCLES;
  localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + RESET_CYCLES + 6 * 200;

  logic                              busClk;
  logic                              rstN;
  logic [neoPixelPkg::ADDR_BITS-1:0] busAddr;
  logic [neoPixelPkg::DATA_BITS-1:0] busDataIn;
  logic                              busWrite;
  logic                              busRead;
  logic [neoPixelPkg::DATA_BITS-1:0] busDataOut;
  logic                              busReady;
  logic                              syncStart;
  logic                              pixelOut;

  logic [7:0] rawModel [0:BUFFER_END]; // expected raw buffer contents
  logic [7:0] decoded [$];             // bytes recovered from pixelOut
  logic [7:0] curByte;
  int         highCnt = 0;
  int         bitsSeen = 0;
  int         highSamples = 0;
  int         valueErrors = 0;
  int         otherErrors = 0;
  int         cycleCount = 0;
  integer     seed;

  neoPixelTop #(
    .BUFFER_END(BUFFER_END),
    .VIRTUAL_END(VIRTUAL_END),
    .BIT_CYCLES(BIT_CYCLES),
    .T0H_CYCLES(T0H_CYCLES),
    .T1H_CYCLES(T1H_CYCLES),
    .RESET_CYCLES(RESET_CYCLES)
  ) DUT (
    .busClk(busClk),
    .rstN(rstN),
    .busAddr(busAddr),
    .busDataIn(busDataIn),
    .busWrite(busWrite),
    .busRead(busRead),
    .busDataOut(busDataOut),
    .busReady(busReady),
    .syncStart(syncStart),
    .pixelOut(pixelOut)
  );

  initial begin
    busClk = 1'b0;
    forever #20 busClk = ~busClk;
  end

  initial begin
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge busClk);
      cycleCount = cycleCount + 1;
    end
    $display("timeout: the DUT gave no response within %0d cycles", cycleCount);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // a bit is a one when its high time passes the midpoint of T0H and T1H
  always @(negedge busClk) begin
    if (pixelOut) begin
      highCnt = highCnt + 1;
      highSamples = highSamples + 1;
    end else if (highCnt != 0) begin
      curByte = {curByte[6:0], (2 * highCnt > T0H_CYCLES + T1H_CYCLES)};
      highCnt = 0;
      bitsSeen = bitsSeen + 1;
      if (bitsSeen == 8) begin
        decoded.push_back(curByte);
        bitsSeen = 0;
      end
    end
  end

  function automatic logic [neoPixelPkg::ADDR_BITS-1:0] addrOf(input logic [1:0] region,
                                                               input int offset);
    return {region, 16'(offset)};
  endfunction

  function automatic logic [neoPixelPkg::ADDR_BITS-1:0] regAddr(input logic [3:0] ix);
    return {neoPixelPkg::REG_REGION, 12'd0, ix};
  endfunction

  task automatic busWriteByte(input logic [neoPixelPkg::ADDR_BITS-1:0] addr,
                              input logic [neoPixelPkg::DATA_BITS-1:0] data);
    @(posedge busClk);
    busAddr   <= addr;
    busDataIn <= data;
    busWrite  <= 1'b1;
    @(posedge busClk);
    busWrite  <= 1'b0;
  endtask

  task automatic busReadByte(input logic [neoPixelPkg::ADDR_BITS-1:0] addr,
                             output logic [neoPixelPkg::DATA_BITS-1:0] data);
    @(posedge busClk);
    busAddr <= addr;
    busRead <= 1'b1;
    @(posedge busClk);
    busRead <= 1'b0;
    @(negedge busClk);
    data = busDataOut;
  endtask

  task automatic writeDelta(input int ix, input logic [15:0] word);
    busWriteByte(addrOf(neoPixelPkg::DELTA_REGION, 2 * ix), word[7:0]);
    busWriteByte(addrOf(neoPixelPkg::DELTA_REGION, 2 * ix + 1), word[15:8]);
  endtask

  task automatic pulseSync();
    @(posedge busClk);
    syncStart <= 1'b1;
    @(posedge busClk);
    syncStart <= 1'b0;
  endtask

  task automatic waitReady();
    @(negedge busClk);
    while (!busReady) @(negedge busClk);
  endtask

  task automatic waitBytes(input int count);
    while (decoded.size() < count) @(negedge busClk);
  endtask

  task automatic waitIdle();
    logic [7:0] st;
    st = 8'h01;
    while (st[0]) busReadByte(regAddr(neoPixelPkg::REG_STATE), st);
  endtask

  task automatic checkByte(input string name, input logic [neoPixelPkg::DATA_BITS-1:0] expected,
                           input logic [neoPixelPkg::DATA_BITS-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      valueErrors = valueErrors + 1;
    end
  endtask

  task automatic checkMax(input string name, input logic [neoPixelPkg::MAX_BITS-1:0] expected,
                          input logic [neoPixelPkg::MAX_BITS-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      valueErrors = valueErrors + 1;
    end
  endtask

  task automatic noteProblem(input string what);
    $display("%s", what);
    otherErrors = otherErrors + 1;
  endtask

  // every frame in these tests covers raw bytes 0..7
  task automatic checkFrames(input string name, input int base, input int frames);
    for (int f = 0; f < frames; f++) begin
      for (int i = 0; i < 8; i++) begin
        checkByte($sformatf("%s frame %0d byte %0d", name, f, i), rawModel[i],
                  decoded[base + 8 * f + i]);
      end
    end
    if (decoded.size() != base + 8 * frames) begin
      noteProblem($sformatf("%s: the line carried more bytes than expected", name));
    end
  endtask

  task automatic testRegisters();
    logic [7:0] lo;
    logic [7:0] hi;
    busWriteByte(regAddr(neoPixelPkg::REG_MAX_LO), 8'hA5);
    busWriteByte(regAddr(neoPixelPkg::REG_MAX_HI), 8'hFF);
    busReadByte(regAddr(neoPixelPkg::REG_MAX_LO), lo);
    busReadByte(regAddr(neoPixelPkg::REG_MAX_HI), hi);
    checkByte("registers max high", 8'h1F, hi); // only five bits exist above the low byte
    checkMax("registers max", 13'h1FA5, {hi[neoPixelPkg::MAX_BITS-9:0], lo});
    busWriteByte(regAddr(neoPixelPkg::REG_WIDTH_LO), 8'h34);
    busWriteByte(regAddr(neoPixelPkg::REG_WIDTH_HI), 8'hFF);
    busWriteByte(regAddr(neoPixelPkg::REG_HEIGHT_LO), 8'h12);
    busWriteByte(regAddr(neoPixelPkg::REG_HEIGHT_HI), 8'hC7);
    busReadByte(regAddr(neoPixelPkg::REG_WIDTH_LO), lo);
    checkByte("registers width low", 8'h34, lo);
    busReadByte(regAddr(neoPixelPkg::REG_WIDTH_HI), hi);
    checkByte("registers width high", 8'h3F, hi);
    busReadByte(regAddr(neoPixelPkg::REG_HEIGHT_LO), lo);
    checkByte("registers height low", 8'h12, lo);
    busReadByte(regAddr(neoPixelPkg::REG_HEIGHT_HI), hi);
    checkByte("registers height high", 8'h07, hi);
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'hFA); // limit, loop and 32-bit, run off
    busReadByte(regAddr(neoPixelPkg::REG_CTRL), lo);
    checkByte("registers ctrl", 8'h1A, lo);
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'h00);
    busReadByte(regAddr(neoPixelPkg::REG_STATE), lo);
    checkByte("registers state idle", 8'h00, lo);
    busReadByte(addrOf(neoPixelPkg::VIRT_REGION, 3), lo);
    checkByte("registers virtual read", 8'hFF, lo);
    busReadByte(addrOf(neoPixelPkg::DELTA_REGION, 3), lo);
    checkByte("registers delta read", 8'hFF, lo);
    busReadByte(addrOf(neoPixelPkg::RAW_REGION, 3), lo);
    checkByte("registers raw read", 8'hFF, lo);
  endtask

  task automatic testDirect();
    logic [7:0] rd;
    int         base;
    for (int i = 0; i < 8; i++) begin
      rawModel[i] = 8'($random(seed));
      busWriteByte(addrOf(neoPixelPkg::RAW_REGION, i), rawModel[i]);
    end
    busWriteByte(regAddr(neoPixelPkg::REG_MAX_LO), 8'h07);
    busWriteByte(regAddr(neoPixelPkg::REG_MAX_HI), 8'h00);
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'h02);
    base = decoded.size();
    pulseSync();
    waitBytes(base + 1);
    busReadByte(regAddr(neoPixelPkg::REG_STATE), rd);
    checkByte("direct state busy", 8'h01, rd);
    waitBytes(base + 8);
    waitIdle();
    checkFrames("direct", base, 1);
    busReadByte(regAddr(neoPixelPkg::REG_CTRL), rd);
    checkByte("direct ctrl after frame", 8'h02, rd);
  endtask

  task automatic testVirtual8();
    logic [7:0] data;
    int         base;
    for (int k = 0; k < 8; k++) begin
      writeDelta(k, 16'((5 * k + 3) % 8)); // a permutation of 0..7
    end
    for (int k = 0; k < 8; k++) begin
      data = 8'($random(seed));
      rawModel[(5 * k + 3) % 8] = data;
      busWriteByte(addrOf(neoPixelPkg::VIRT_REGION, k), data);
      @(negedge busClk);
      if (busReady) begin
        noteProblem($sformatf("virtual8: busReady stayed high after write %0d", k));
      end
      waitReady();
    end
    base = decoded.size();
    pulseSync();
    waitBytes(base + 8);
    waitIdle();
    checkFrames("virtual8", base, 1);
  endtask

  task automatic testVirtual32();
    int         pixelOf [2] = '{1, 0};
    logic [7:0] data;
    int         base;
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'h12);
    // the stored channel field is junk, the access address supplies the real one
    writeDelta(0, {14'(pixelOf[0]), 2'd3});
    writeDelta(1, {14'(pixelOf[1]), 2'd2});
    for (int a = 0; a < 8; a++) begin
      data = 8'($random(seed));
      rawModel[4 * pixelOf[a / 4] + a % 4] = data;
      busWriteByte(addrOf(neoPixelPkg::VIRT_REGION, a), data);
      waitReady();
    end
    base = decoded.size();
    pulseSync();
    waitBytes(base + 8);
    waitIdle();
    checkFrames("virtual32", base, 1);
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'h02);
  endtask

  task automatic testLoop();
    logic [7:0] rd;
    int         base;
    base = decoded.size();
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'h0E);
    waitBytes(base + 16);
    // still inside the second latch gap here
    busReadByte(regAddr(neoPixelPkg::REG_CTRL), rd);
    checkByte("loop ctrl while looping", 8'h0E, rd);
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'h06);
    busReadByte(regAddr(neoPixelPkg::REG_CTRL), rd);
    checkByte("loop ctrl before gap end", 8'h06, rd);
    waitIdle();
    busReadByte(regAddr(neoPixelPkg::REG_CTRL), rd);
    checkByte("loop ctrl after last frame", 8'h02, rd);
    checkFrames("loop", base, 2);
  endtask

  task automatic testInit();
    logic [7:0] rd;
    int         base;
    int         highBefore;
    base = decoded.size();
    highBefore = highSamples;
    busWriteByte(regAddr(neoPixelPkg::REG_CTRL), 8'h1B);
    busReadByte(regAddr(neoPixelPkg::REG_CTRL), rd);
    checkByte("init ctrl cleared", 8'h01, rd);
    while (rd[neoPixelPkg::CTRL_INIT]) busReadByte(regAddr(neoPixelPkg::REG_CTRL), rd);
    checkByte("init ctrl done", 8'h00, rd);
    busReadByte(regAddr(neoPixelPkg::REG_STATE), rd);
    checkByte("init state after done", 8'h00, rd);
    if (highSamples != highBefore || decoded.size() != base) begin
      noteProblem("init: pixelOut went high during the init sequence");
    end
  endtask

  initial begin
    seed      = 32'hce219f52;
    rstN      = 1'b0;
    busAddr   = '0;
    busDataIn = '0;
    busWrite  = 1'b0;
    busRead   = 1'b0;
    syncStart = 1'b0;
    repeat (3) @(posedge busClk);
    rstN <= 1'b1;
    @(negedge busClk);
    if (!busReady || pixelOut) begin
      noteProblem("reset: busReady should be high and pixelOut low");
    end
    testRegisters();
    testDirect();
    testVirtual8();
    testVirtual32();
    testLoop();
    testInit();
    $display("errors: %0d value mismatches, %0d other problems", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/neoPixelPkg.sv
src/pixelRam.sv
src/neoPixelRegisters.sv
src/pixelStreamer.sv
src/neoPixelTop.sv
sim/neoPixelTb.sv

// ==== Makefile ====
TOP = neoPixelTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
